// File: logic/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Native bus widths
`define SOC_ADDR_W        32
`define SOC_DATA_W        32
`define SOC_STRB_W        4
// Word offset width towards the slaves, sized for the scratch memory
`define SOC_OFFS_W        8

// Address map
`define SOC_MEM_BASE      32'h0000_0000
`define SOC_MEM_WORDS     256
`define SOC_CORDIC_BASE   32'h1000_0000
`define SOC_CORDIC_SPAN   32'h0000_0020

// CORDIC register byte offsets
`define SOC_REG_CTRL      32'h0000_0000
`define SOC_REG_STATUS    32'h0000_0004
`define SOC_REG_ANGLE     32'h0000_0008
`define SOC_REG_COS       32'h0000_000C
`define SOC_REG_SIN       32'h0000_0010

// CORDIC engine
`define SOC_CORDIC_ITERS  16
// Inverse CORDIC gain, Q2.14
`define SOC_CORDIC_GAIN   16'h26DD

// Read data of an unmapped access
`define SOC_FAULT_WORD    32'hDEAD_BEEF

`endif

// File: logic/soc_pkg.sv
package soc_pkg;

    // Target of the current bus access
    typedef enum logic [1:0] {
        SEL_MEM,
        SEL_CORDIC,
        SEL_NONE
    } slave_sel_t;

    // Fault response sequencing in the decoder
    typedef enum logic {
        BS_IDLE,
        BS_FAULT
    } bus_state_t;

    // CORDIC engine and status tracking
    typedef enum logic [1:0] {
        CS_IDLE,
        CS_RUN,
        CS_DONE
    } cordic_state_t;

    // Signed Q2.14 sample
    typedef logic signed [15:0] fix16_t;

endpackage

// File: logic/bus_decoder.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_decoder (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   mem_valid,
    input  logic [`SOC_ADDR_W-1:0] mem_addr,
    input  logic [`SOC_STRB_W-1:0] mem_wstrb,
    output logic                   mem_ready,
    output logic [`SOC_DATA_W-1:0] mem_rdata,
    output logic                   trap,
    output logic [`SOC_OFFS_W-1:0] slv_offset,
    output logic                   mem_sel_valid,
    input  logic                   mem_sel_ready,
    input  logic [`SOC_DATA_W-1:0] mem_sel_rdata,
    output logic                   cordic_sel_valid,
    input  logic                   cordic_sel_ready,
    input  logic [`SOC_DATA_W-1:0] cordic_sel_rdata
);
    import soc_pkg::*;

    logic [`SOC_ADDR_W-1:0] mem_rel;
    logic [`SOC_ADDR_W-1:0] cordic_rel;
    slave_sel_t             sel;
    bus_state_t             state;

    // Offsets relative to each region base, wraps below the base
    assign mem_rel    = mem_addr - `SOC_MEM_BASE;
    assign cordic_rel = mem_addr - `SOC_CORDIC_BASE;

    always_comb begin
        if (mem_rel < `SOC_ADDR_W'(`SOC_MEM_WORDS * 4)) begin
            sel = SEL_MEM;
        end else if (cordic_rel < `SOC_CORDIC_SPAN) begin
            sel = SEL_CORDIC;
        end else begin
            sel = SEL_NONE;
        end
    end

    // Both region bases leave the offset bits clear
    assign slv_offset = mem_addr[`SOC_OFFS_W+1:2];

    assign mem_sel_valid    = mem_valid && (sel == SEL_MEM);
    assign cordic_sel_valid = mem_valid && (sel == SEL_CORDIC);

    // Fault responder, one ready per unmapped access; trap never clears
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= BS_IDLE;
            trap  <= 1'b0;
        end else begin
            case (state)
                BS_IDLE: begin
                    if (mem_valid && (sel == SEL_NONE)) begin
                        state <= BS_FAULT;
                        trap  <= 1'b1;
                    end
                end
                default: state <= BS_IDLE;
            endcase
        end
    end

    // Response path follows the decoded target
    always_comb begin
        case (sel)
            SEL_MEM: begin
                mem_ready = mem_sel_ready;
                mem_rdata = mem_sel_rdata;
            end
            SEL_CORDIC: begin
                mem_ready = cordic_sel_ready;
                mem_rdata = cordic_sel_rdata;
            end
            default: begin
                mem_ready = (state == BS_FAULT);
                mem_rdata = (mem_wstrb == '0) ? `SOC_FAULT_WORD : '0;
            end
        endcase
    end

endmodule

// File: logic/scratch_mem.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module scratch_mem (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   sel_valid,
    input  logic [`SOC_OFFS_W-1:0] offset,
    input  logic [`SOC_DATA_W-1:0] wdata,
    input  logic [`SOC_STRB_W-1:0] wstrb,
    output logic                   sel_ready,
    output logic [`SOC_DATA_W-1:0] rdata
);

    logic [`SOC_DATA_W-1:0] mem [`SOC_MEM_WORDS];
    logic                   accept;

    // New access only while no ready is pending
    assign accept = sel_valid && !sel_ready;

    // Ready doubles as the one-shot flag for a held select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_ready <= 1'b0;
        end else begin
            sel_ready <= accept;
        end
    end

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int lane = 0; lane < `SOC_STRB_W; lane++) begin
                if (wstrb[lane]) begin
                    mem[offset][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read, old contents on a write cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[offset];
        end
    end

endmodule

// File: logic/cordic_core.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module cordic_core (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  soc_pkg::fix16_t angle,
    output logic            busy,
    output logic            finish,
    output soc_pkg::fix16_t cos_out,
    output soc_pkg::fix16_t sin_out
);
    import soc_pkg::*;

    localparam int ITER_W = $clog2(`SOC_CORDIC_ITERS);
    localparam logic [ITER_W-1:0] LAST_ITER = ITER_W'(`SOC_CORDIC_ITERS - 1);

    cordic_state_t     state;
    logic [ITER_W-1:0] iter;
    fix16_t            x;
    fix16_t            y;
    fix16_t            z;
    fix16_t            x_shift;
    fix16_t            y_shift;
    fix16_t            atan_i;

    // atan(2^-i) in Q2.14, rounded to nearest
    function automatic fix16_t atan_lut(input logic [ITER_W-1:0] i);
        case (i)
            0:       atan_lut = 16'sd12868;
            1:       atan_lut = 16'sd7596;
            2:       atan_lut = 16'sd4014;
            3:       atan_lut = 16'sd2037;
            4:       atan_lut = 16'sd1023;
            5:       atan_lut = 16'sd512;
            6:       atan_lut = 16'sd256;
            7:       atan_lut = 16'sd128;
            8:       atan_lut = 16'sd64;
            9:       atan_lut = 16'sd32;
            10:      atan_lut = 16'sd16;
            11:      atan_lut = 16'sd8;
            12:      atan_lut = 16'sd4;
            13:      atan_lut = 16'sd2;
            14:      atan_lut = 16'sd1;
            // Rounds to zero from here on
            default: atan_lut = 16'sd0;
        endcase
    endfunction

    assign x_shift = x >>> iter;
    assign y_shift = y >>> iter;
    assign atan_i  = atan_lut(iter);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CS_IDLE;
            iter  <= '0;
        end else begin
            case (state)
                CS_IDLE: begin
                    if (start) begin
                        state <= CS_RUN;
                        iter  <= '0;
                    end
                end
                CS_RUN: begin
                    if (iter == LAST_ITER) begin
                        state <= CS_DONE;
                    end else begin
                        iter <= iter + 1'b1;
                    end
                end
                default: state <= CS_IDLE;
            endcase
        end
    end

    // Rotation mode, drive z towards zero
    always_ff @(posedge clk) begin
        if ((state == CS_IDLE) && start) begin
            x <= `SOC_CORDIC_GAIN;
            y <= '0;
            z <= angle;
        end else if (state == CS_RUN) begin
            if (!z[15]) begin
                x <= x - y_shift;
                y <= y + x_shift;
                z <= z - atan_i;
            end else begin
                x <= x + y_shift;
                y <= y - x_shift;
                z <= z + atan_i;
            end
        end
    end

    assign busy    = (state != CS_IDLE);
    assign finish  = (state == CS_DONE);
    assign cos_out = x;
    assign sin_out = y;

endmodule

// File: logic/cordic_regs.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module cordic_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   sel_valid,
    input  logic [`SOC_OFFS_W-1:0] offset,
    input  logic [`SOC_DATA_W-1:0] wdata,
    input  logic [`SOC_STRB_W-1:0] wstrb,
    output logic                   sel_ready,
    output logic [`SOC_DATA_W-1:0] rdata
);
    import soc_pkg::*;

    logic [`SOC_ADDR_W-1:0] reg_addr;
    logic                   accept;
    logic                   wr_en;
    logic                   start;
    logic                   core_busy;
    logic                   core_finish;
    fix16_t                 angle;
    fix16_t                 core_cos;
    fix16_t                 core_sin;
    fix16_t                 cos_q;
    fix16_t                 sin_q;
    cordic_state_t          status_state;

    assign reg_addr = {{(`SOC_ADDR_W - `SOC_OFFS_W - 2){1'b0}}, offset, 2'b00};
    assign accept   = sel_valid && !sel_ready;
    assign wr_en    = accept && (wstrb != '0);

    // CTRL bit 0 sits in byte lane 0; ignored while the engine runs
    assign start = wr_en && (reg_addr == `SOC_REG_CTRL) && wstrb[0] && wdata[0] && !core_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_ready <= 1'b0;
            angle     <= '0;
        end else begin
            sel_ready <= accept;
            if (wr_en && (reg_addr == `SOC_REG_ANGLE)) begin
                if (wstrb[0]) angle[7:0]  <= wdata[7:0];
                if (wstrb[1]) angle[15:8] <= wdata[15:8];
            end
        end
    end

    // Status tracking and result capture on finish
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_state <= CS_IDLE;
            cos_q        <= '0;
            sin_q        <= '0;
        end else if (core_finish) begin
            status_state <= CS_DONE;
            cos_q        <= core_cos;
            sin_q        <= core_sin;
        end else if (start) begin
            status_state <= CS_RUN;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (reg_addr)
                `SOC_REG_STATUS: rdata <= {{(`SOC_DATA_W - 2){1'b0}},
                                           status_state == CS_DONE,
                                           status_state == CS_RUN};
                `SOC_REG_ANGLE:  rdata <= {{(`SOC_DATA_W - 16){angle[15]}}, angle};
                `SOC_REG_COS:    rdata <= {{(`SOC_DATA_W - 16){cos_q[15]}}, cos_q};
                `SOC_REG_SIN:    rdata <= {{(`SOC_DATA_W - 16){sin_q[15]}}, sin_q};
                default:         rdata <= '0;
            endcase
        end
    end

    cordic_core cordic_core_i (
        .clk(clk),
        .arst_n(arst_n),
        .start(start),
        .angle(angle),
        .busy(core_busy),
        .finish(core_finish),
        .cos_out(core_cos),
        .sin_out(core_sin)
    );

endmodule

// File: logic/soc_top.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_top (
    input  logic                   clk,
    input  logic                   arst_n,

    // Processor-side native memory bus
    input  logic                   mem_valid,
    output logic                   mem_ready,
    input  logic [`SOC_ADDR_W-1:0] mem_addr,
    input  logic [`SOC_DATA_W-1:0] mem_wdata,
    input  logic [`SOC_STRB_W-1:0] mem_wstrb,
    output logic [`SOC_DATA_W-1:0] mem_rdata,

    // Sticky bus fault
    output logic                   trap
);

    logic [`SOC_OFFS_W-1:0] slv_offset;

    logic                   mem_sel_valid;
    logic                   mem_sel_ready;
    logic [`SOC_DATA_W-1:0] mem_sel_rdata;

    logic                   cordic_sel_valid;
    logic                   cordic_sel_ready;
    logic [`SOC_DATA_W-1:0] cordic_sel_rdata;

    bus_decoder bus_decoder_i (
        .clk(clk),
        .arst_n(arst_n),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata),
        .trap(trap),
        .slv_offset(slv_offset),
        .mem_sel_valid(mem_sel_valid),
        .mem_sel_ready(mem_sel_ready),
        .mem_sel_rdata(mem_sel_rdata),
        .cordic_sel_valid(cordic_sel_valid),
        .cordic_sel_ready(cordic_sel_ready),
        .cordic_sel_rdata(cordic_sel_rdata)
    );

    // Scratch memory in place of the DRAM controller
    scratch_mem scratch_mem_i (
        .clk(clk),
        .arst_n(arst_n),
        .sel_valid(mem_sel_valid),
        .offset(slv_offset),
        .wdata(mem_wdata),
        .wstrb(mem_wstrb),
        .sel_ready(mem_sel_ready),
        .rdata(mem_sel_rdata)
    );

    cordic_regs cordic_regs_i (
        .clk(clk),
        .arst_n(arst_n),
        .sel_valid(cordic_sel_valid),
        .offset(slv_offset),
        .wdata(mem_wdata),
        .wstrb(mem_wstrb),
        .sel_ready(cordic_sel_ready),
        .rdata(cordic_sel_rdata)
    );

endmodule

// File: tests/soc_tb.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int CLK_HALF        = 10;
    localparam int DRV_DELAY       = 2;
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_LINE = 40;
    localparam int READY_WAIT_MAX  = 8;
    localparam string STIM_FILE    = "tests/soc_stimulus.txt";

    localparam logic [31:0] CTRL_ADDR   = `SOC_CORDIC_BASE + `SOC_REG_CTRL;
    localparam logic [31:0] STATUS_ADDR = `SOC_CORDIC_BASE + `SOC_REG_STATUS;
    localparam logic [31:0] ANGLE_ADDR  = `SOC_CORDIC_BASE + `SOC_REG_ANGLE;
    localparam logic [31:0] COS_ADDR    = `SOC_CORDIC_BASE + `SOC_REG_COS;
    localparam logic [31:0] SIN_ADDR    = `SOC_CORDIC_BASE + `SOC_REG_SIN;

    logic        clk;
    logic        arst_n;
    logic        mem_valid;
    logic        mem_ready;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic [31:0] mem_rdata;
    logic        trap;

    // One queue per stimulus column
    logic [7:0]  tag_q[$];
    logic [31:0] col_a[$];
    logic [31:0] col_b[$];
    logic [31:0] col_c[$];
    logic [31:0] col_d[$];
    logic [31:0] col_e[$];

    int   cycle_count;
    int   cycle_limit;
    int   ready_cycle;
    logic trap_exp;

    soc_top dut_i (
        .clk(clk),
        .arst_n(arst_n),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .mem_rdata(mem_rdata),
        .trap(trap)
    );

    always #CLK_HALF clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_fix(input string name, input fix16_t got, input fix16_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%04h, expected 0x%04h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_stimulus();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [31:0]      d;
        logic [31:0]      e;
        logic [8*160-1:0] line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            abort_run();
        end
        forever begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) break;
            if (tag == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                if (code != 5) begin
                    $display("Stimulus line with tag %c has missing columns", tag);
                    abort_run();
                end
                tag_q.push_back(tag);
                col_a.push_back(a);
                col_b.push_back(b);
                col_c.push_back(c);
                col_d.push_back(d);
                col_e.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // Called a short delay after a rising edge, returns at the same point
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
        int waited;
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        // Response sampled mid-cycle
        @(negedge clk);
        waited = 1;
        while (!mem_ready && waited < READY_WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!mem_ready) begin
            $display("No mem_ready for the access to 0x%08h within %0d cycles",
                     addr, READY_WAIT_MAX);
            abort_run();
        end
        rdata       = mem_rdata;
        ready_cycle = cycle_count;
        check_word("mem_ready latency", waited - 1, 32'd1);
        check_bit("trap", trap, trap_exp);
        @(posedge clk);
        #DRV_DELAY;
        mem_valid = 1'b0;
        mem_wstrb = '0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
        logic [31:0] ignored;
        bus_access(addr, wdata, wstrb, ignored);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_access(addr, 32'h0, 4'h0, rdata);
    endtask

    task automatic start_cordic(input logic [31:0] angle, output int start_cycle);
        bus_write(ANGLE_ADDR, angle, 4'hF);
        bus_write(CTRL_ADDR, 32'h1, 4'hF);
        start_cycle = ready_cycle;
    endtask

    // Polls back to back so the done latency stays measurable
    task automatic wait_cordic_done(input int start_cycle);
        logic [31:0] status;
        int          elapsed;
        bus_read(STATUS_ADDR, status);
        while (status[1] == 1'b0) begin
            check_word("STATUS while busy", status, 32'h0000_0001);
            bus_read(STATUS_ADDR, status);
        end
        check_word("STATUS when done", status, 32'h0000_0002);
        // One extra cycle for the read that sees done
        elapsed = ready_cycle - start_cycle;
        if (elapsed > `SOC_CORDIC_ITERS + 2) begin
            $display("CORDIC done was seen %0d cycles after the start write, too late",
                     elapsed);
            abort_run();
        end
    endtask

    task automatic check_cordic_result(input fix16_t cos_exp, input fix16_t sin_exp);
        logic [31:0] rdata;
        bus_read(COS_ADDR, rdata);
        check_fix("COS", fix16_t'(rdata[15:0]), cos_exp);
        check_word("COS sign extension", rdata, {{16{cos_exp[15]}}, cos_exp});
        bus_read(SIN_ADDR, rdata);
        check_fix("SIN", fix16_t'(rdata[15:0]), sin_exp);
        check_word("SIN sign extension", rdata, {{16{sin_exp[15]}}, sin_exp});
    endtask

    task automatic run_line(input int n);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] rdata;
        int          start_cycle;
        a = col_a[n];
        b = col_b[n];
        c = col_c[n];
        d = col_d[n];
        e = col_e[n];
        case (tag_q[n])
            "W": bus_write(a, b, c[3:0]);
            "R": begin
                bus_read(a, rdata);
                check_word($sformatf("mem_rdata at 0x%08h", a), rdata, d);
            end
            "C": begin
                start_cordic(a, start_cycle);
                wait_cordic_done(start_cycle);
                check_cordic_result(fix16_t'(d[15:0]), fix16_t'(e[15:0]));
            end
            "B": begin
                start_cordic(a, start_cycle);
                // New angle and start while the engine runs
                bus_write(ANGLE_ADDR, b, 4'hF);
                bus_write(CTRL_ADDR, 32'h1, 4'hF);
                wait_cordic_done(start_cycle);
                check_cordic_result(fix16_t'(d[15:0]), fix16_t'(e[15:0]));
            end
            "U": begin
                // Trap rises together with this ready
                trap_exp = 1'b1;
                if (c[3:0] == 4'h0) begin
                    bus_read(a, rdata);
                    check_word($sformatf("mem_rdata at unmapped 0x%08h", a), rdata, d);
                end else begin
                    bus_write(a, b, c[3:0]);
                end
            end
            default: begin
                $display("Unknown stimulus tag %c on data line %0d", tag_q[n], n + 1);
                abort_run();
            end
        endcase
    endtask

    initial begin
        int gap;
        clk         = 1'b0;
        arst_n      = 1'b0;
        mem_valid   = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_wstrb   = '0;
        trap_exp    = 1'b0;
        cycle_count = 0;
        void'($urandom(32'h9fd0));
        load_stimulus();
        cycle_limit = tag_q.size() * CYCLES_PER_LINE + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRV_DELAY;
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("mem_ready after reset", mem_ready, 1'b0);
        check_bit("trap after reset", trap, 1'b0);
        @(posedge clk);
        #DRV_DELAY;

        for (int n = 0; n < tag_q.size(); n++) begin
            run_line(n);
            // Idle gap of 0 to 3 cycles
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #DRV_DELAY;
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: tests/soc_stimulus.txt
# tag addr_or_angle data_or_angle2 strobes expect_or_cos sin, all hex
# W write, R read, C CORDIC run, B start while busy, U unmapped access
R 10000004 0 0 00000000 0
R 1000000C 0 0 00000000 0
R 10000010 0 0 00000000 0
W 00000000 11223344 F 0 0
W 00000004 AABBCCDD F 0 0
W 00000008 CAFEF00D F 0 0
W 00000010 00C0FFEE F 0 0
W 000003FC 0F1E2D3C F 0 0
W 00000000 99887766 1 0 0
W 00000004 55443322 6 0 0
W 00000008 12345678 C 0 0
W 000003FC FFFFFFFF 8 0 0
R 00000000 0 0 11223366 0
R 00000004 0 0 AA4433DD 0
R 00000008 0 0 1234F00D 0
R 00000010 0 0 00C0FFEE 0
R 000003FC 0 0 FF1E2D3C 0
C 00000000 0 0 3FFF 0004
C 0000E000 0 0 3829 E156
B 00000000 0000E000 0 3FFF 0004
R 10000004 0 0 00000002 0
U 20000000 0 0 DEADBEEF 0
U 10000020 0 0 DEADBEEF 0
U 20000010 5A5A5A5A F 0 0
U 00000400 77777777 F 0 0
R 00000000 0 0 11223366 0
R 00000010 0 0 00C0FFEE 0
R 000003FC 0 0 FF1E2D3C 0

// File: build.f
+incdir+logic
logic/soc_pkg.sv
logic/bus_decoder.sv
logic/scratch_mem.sv
logic/cordic_core.sv
logic/cordic_regs.sv
logic/soc_top.sv
tests/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SoC fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module soc_tb -o soc_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/soc_tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
